//--- rv_exec.f
rv_exec_pkg.sv
inst_decoder.sv
credit_fifo.sv
exu_alu.sv
exu_pc.sv
exu_stage.sv
rv_exec.sv
rv_exec_sva.sv
tb_rv_exec.sv

//--- Makefile
TOP := tb_rv_exec

all: run

run:
	verilator --binary --assert -j 0 --top-module $(TOP) -f rv_exec.f -o sim
	out="$$(./obj_dir/sim 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "PASS: all tests"

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f rv_exec.f

clean:
	rm -rf obj_dir

.PHONY: all run lint clean

//--- tb_rv_exec.sv
module tb_rv_exec;
    import rv_exec_pkg::*;

    localparam int NUM_INSTS = 400;
    localparam int LIMIT     = NUM_INSTS * 4 + 100;

    logic     clk;
    logic     arst_n;
    logic     inst_valid;
    inst_in_t inst;
    logic     res_ready;
    logic     inst_ready;
    logic     res_valid;
    result_t  res;

    inst_in_t        pending[$];
    logic [XLEN-1:0] model_pc;
    int              sent;
    int              checked;
    int              cycle_count;
    logic            in_fire;

    rv_exec DUT (
        .clk       (clk),
        .arst_n    (arst_n),
        .inst_valid(inst_valid),
        .inst      (inst),
        .res_ready (res_ready),
        .inst_ready(inst_ready),
        .res_valid (res_valid),
        .res       (res)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stop_run();
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %s: got 0x%08h expected 0x%08h", name, got, exp);
            stop_run();
        end
    endtask

    function automatic inst_in_t random_inst();
        inst_in_t    in;
        logic [31:0] r;
        logic [4:0]  rd;
        int unsigned kind;
        r       = $urandom;
        rd      = ($urandom % 4 == 0) ? 5'd0 : 5'($urandom);
        kind    = $urandom % 14;
        in.src1 = $urandom;
        // Equal operands now and then, so branches go both ways.
        in.src2 = ($urandom % 3 == 0) ? in.src1 : $urandom;
        case (kind)
            0:       in.word = {7'h00, r[24:15], 3'd0, rd, 7'h33};
            1:       in.word = {7'h20, r[24:15], 3'd0, rd, 7'h33};
            2:       in.word = {7'h00, r[24:15], 3'd3, rd, 7'h33};
            3:       in.word = {r[31:15], 3'd0, rd, 7'h13};
            4:       in.word = {r[31:15], 3'd4, rd, 7'h13};
            5:       in.word = {r[31:15], 3'd7, rd, 7'h13};
            6:       in.word = {r[31:12], rd, 7'h17};
            7:       in.word = {r[31:12], rd, 7'h6f};
            8:       in.word = {r[31:15], 3'd0, rd, 7'h67};
            9:       in.word = {r[31:15], 3'd0, r[11:7], 7'h63};
            10:      in.word = {r[31:15], 3'd1, r[11:7], 7'h63};
            11:      in.word = {r[31:15], 3'd5, r[11:7], 7'h63};
            12:      in.word = 32'h0010_0073;
            default: in.word = {r[31:7], 7'h03};
        endcase
        return in;
    endfunction

    // Reference model straight from the RV32I encodings.
    function automatic result_t model_result(input inst_in_t in, input logic [XLEN-1:0] pc);
        result_t         r;
        logic [XLEN-1:0] w;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] imm_i;
        logic [XLEN-1:0] imm_b;
        logic [XLEN-1:0] imm_j;
        logic [6:0]      opc;
        logic [2:0]      f3;
        logic [6:0]      f7;
        logic            wr;
        w       = in.word;
        a       = in.src1;
        b       = in.src2;
        opc     = w[6:0];
        f3      = w[14:12];
        f7      = w[31:25];
        imm_i   = 32'($signed(w) >>> 20);
        imm_b   = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        imm_j   = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        r       = '0;
        r.pc    = pc;
        r.rd    = w[11:7];
        r.next_pc = pc + 32'd4;
        wr      = 1'b1;
        if (opc == 7'h33 && f7 == 7'h00 && f3 == 3'd0) r.wdata = a + b;
        else if (opc == 7'h33 && f7 == 7'h20 && f3 == 3'd0) r.wdata = a - b;
        else if (opc == 7'h33 && f7 == 7'h00 && f3 == 3'd3) r.wdata = (a < b) ? 32'd1 : 32'd0;
        else if (opc == 7'h13 && f3 == 3'd0) r.wdata = a + imm_i;
        else if (opc == 7'h13 && f3 == 3'd4) r.wdata = a ^ imm_i;
        else if (opc == 7'h13 && f3 == 3'd7) r.wdata = a & imm_i;
        else if (opc == 7'h17) r.wdata = pc + {w[31:12], 12'h000};
        else if (opc == 7'h6f) begin
            r.wdata   = pc + 32'd4;
            r.next_pc = pc + imm_j;
        end else if (opc == 7'h67 && f3 == 3'd0) begin
            r.wdata   = pc + 32'd4;
            r.next_pc = (a + imm_i) & ~32'd1;
        end else begin
            wr = 1'b0;
            if (opc == 7'h63 && f3 == 3'd0 && a == b) r.next_pc = pc + imm_b;
            else if (opc == 7'h63 && f3 == 3'd1 && a != b) r.next_pc = pc + imm_b;
            else if (opc == 7'h63 && f3 == 3'd5 && $signed(a) >= $signed(b))
                r.next_pc = pc + imm_b;
            else if (w == 32'h0010_0073) r.halt = 1'b1;
            else if (!(opc == 7'h63 && (f3 == 3'd0 || f3 == 3'd1 || f3 == 3'd5)))
                r.illegal = 1'b1;
        end
        r.wen = wr && (r.rd != 5'd0);
        return r;
    endfunction

    task automatic check_result();
        inst_in_t in;
        result_t  exp;
        if (pending.size() == 0) begin
            $display("A result appeared with no instruction outstanding");
            stop_run();
        end else begin
            in  = pending.pop_front();
            exp = model_result(in, model_pc);
            check("res.pc", res.pc, exp.pc);
            check("res.next_pc", res.next_pc, exp.next_pc);
            check("res.rd", 32'(res.rd), 32'(exp.rd));
            check("res.wen", 32'(res.wen), 32'(exp.wen));
            check("res.halt", 32'(res.halt), 32'(exp.halt));
            check("res.illegal", 32'(res.illegal), 32'(exp.illegal));
            if (exp.wen) begin
                check("res.wdata", res.wdata, exp.wdata);
            end
            model_pc = exp.next_pc;
        end
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", LIMIT);
            stop_run();
        end
    end

    initial begin
        void'($urandom(63));
        arst_n      = 1'b0;
        inst_valid  = 1'b0;
        inst        = '0;
        res_ready   = 1'b0;
        model_pc    = RESET_PC;
        sent        = 0;
        checked     = 0;
        cycle_count = 0;
        in_fire     = 1'b0;
        repeat (3) @(negedge clk);
        arst_n = 1'b1;
        check("res_valid", 32'(res_valid), 32'd0);
        check("inst_ready", 32'(inst_ready), 32'd1);

        // Handshakes are decided at the falling edge and happen at the next rising edge.
        while (checked < NUM_INSTS) begin
            @(negedge clk);
            if (!inst_ready && pending.size() < FIFO_DEPTH) begin
                $display("inst_ready is low with only %0d instructions in flight",
                         pending.size());
                stop_run();
            end
            if (!inst_valid || in_fire) begin
                if (sent < NUM_INSTS && ($urandom % 4) != 0) begin
                    inst_valid = 1'b1;
                    inst       = random_inst();
                end else begin
                    inst_valid = 1'b0;
                end
            end
            res_ready = ($urandom % 4) != 0;
            in_fire   = inst_valid && inst_ready;
            if (in_fire) begin
                pending.push_back(inst);
                sent++;
            end
            if (res_valid && res_ready) begin
                check_result();
                checked++;
            end
        end

        // No extra result may follow the last one.
        inst_valid = 1'b0;
        res_ready  = 1'b1;
        repeat (8) begin
            @(negedge clk);
            if (res_valid) begin
                $display("An extra result appeared after all instructions completed");
                stop_run();
            end
        end
        $display("PASS: all tests");
        $finish;
    end

endmodule

//--- rv_exec_sva.sv
module credit_fifo_sva #(
    parameter int DEPTH = 4
) (
    input logic                       clk,
    input logic                       arst_n,
    input logic                       push,
    input logic                       pop,
    input logic                       uop_valid,
    input logic [$clog2(DEPTH+1)-1:0] count
);

    // Credits keep the buffer from overflowing.
    no_push_when_full: assert property (
        @(posedge clk) disable iff (!arst_n) push |-> (count < DEPTH)
    ) else $error("push arrived while the buffer was full");

    pop_needs_valid: assert property (
        @(posedge clk) disable iff (!arst_n) pop |-> uop_valid
    ) else $error("pop was high without uop_valid");

    count_in_range: assert property (
        @(posedge clk) disable iff (!arst_n) count <= DEPTH
    ) else $error("buffer occupancy exceeded its depth");

endmodule

bind credit_fifo credit_fifo_sva #(
    .DEPTH(DEPTH)
) u_sva (
    .clk      (clk),
    .arst_n   (arst_n),
    .push     (push),
    .pop      (pop),
    .uop_valid(uop_valid),
    .count    (count)
);

//--- rv_exec.sv
module rv_exec (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  inst_valid,
    input  rv_exec_pkg::inst_in_t inst,
    input  logic                  res_ready,
    output logic                  inst_ready,
    output logic                  res_valid,
    output rv_exec_pkg::result_t  res
);
    import rv_exec_pkg::*;

    logic push;
    uop_t push_uop;
    logic credit_return;
    logic uop_valid;
    uop_t uop;
    logic pop;

    inst_decoder u_decoder (
        .clk          (clk),
        .arst_n       (arst_n),
        .inst_valid   (inst_valid),
        .inst         (inst),
        .credit_return(credit_return),
        .inst_ready   (inst_ready),
        .push         (push),
        .push_uop     (push_uop)
    );

    credit_fifo #(
        .DEPTH(FIFO_DEPTH)
    ) u_fifo (
        .clk          (clk),
        .arst_n       (arst_n),
        .push         (push),
        .push_uop     (push_uop),
        .pop          (pop),
        .uop_valid    (uop_valid),
        .uop          (uop),
        .credit_return(credit_return)
    );

    exu_stage u_exu (
        .clk      (clk),
        .arst_n   (arst_n),
        .uop_valid(uop_valid),
        .uop      (uop),
        .res_ready(res_ready),
        .pop      (pop),
        .res_valid(res_valid),
        .res      (res)
    );

endmodule

//--- exu_stage.sv
module exu_stage (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 uop_valid,
    input  rv_exec_pkg::uop_t    uop,
    input  logic                 res_ready,
    output logic                 pop,
    output logic                 res_valid,
    output rv_exec_pkg::result_t res
);
    import rv_exec_pkg::*;

    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] next_pc;
    logic [XLEN-1:0] wdata;
    logic            writes;

    exu_alu u_alu (
        .uop       (uop),
        .alu_result(alu_result)
    );

    exu_pc u_pc (
        .op        (uop.op),
        .imm       (uop.imm),
        .pc        (pc_q),
        .src1      (uop.src1),
        .alu_result(alu_result),
        .next_pc   (next_pc)
    );

    // Pop when the output register is empty or drains this cycle.
    assign pop = uop_valid && (!res_valid || res_ready);

    always_comb begin
        writes = uop.op inside {OP_ADD, OP_SUB, OP_SLTU, OP_ADDI, OP_XORI, OP_ANDI,
                                OP_AUIPC, OP_JAL, OP_JALR};
        case (uop.op)
            OP_JAL, OP_JALR: wdata = pc_q + XLEN'(4);
            OP_AUIPC:        wdata = pc_q + uop.imm;
            default:         wdata = alu_result;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc_q      <= RESET_PC;
            res_valid <= 1'b0;
        end else if (pop) begin
            pc_q      <= next_pc;
            res_valid <= 1'b1;
        end else if (res_ready) begin
            res_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            res.pc      <= pc_q;
            res.next_pc <= next_pc;
            res.rd      <= uop.rd;
            res.wdata   <= wdata;
            res.wen     <= writes && (uop.rd != 5'd0);
            res.halt    <= (uop.op == OP_EBREAK);
            res.illegal <= (uop.op == OP_ILLEGAL);
        end
    end

endmodule

//--- exu_pc.sv
module exu_pc (
    input  rv_exec_pkg::op_e             op,
    input  logic [rv_exec_pkg::XLEN-1:0] imm,
    input  logic [rv_exec_pkg::XLEN-1:0] pc,
    input  logic [rv_exec_pkg::XLEN-1:0] src1,
    input  logic [rv_exec_pkg::XLEN-1:0] alu_result,
    output logic [rv_exec_pkg::XLEN-1:0] next_pc
);
    import rv_exec_pkg::*;

    logic            is_jalr;
    logic            taken;
    logic [XLEN-1:0] adder_a;
    logic [XLEN-1:0] adder_b;
    logic [XLEN-1:0] sum;

    assign is_jalr = (op == OP_JALR);
    assign taken   = (op inside {OP_BEQ, OP_BNE, OP_BGE}) && alu_result[0];

    // Register-relative target only for jalr.
    assign adder_a = is_jalr ? src1 : pc;
    assign adder_b = (op == OP_JAL || is_jalr || taken) ? imm : XLEN'(4);
    assign sum     = adder_a + adder_b;

    assign next_pc = {sum[XLEN-1:1], sum[0] & ~is_jalr};

endmodule

//--- exu_alu.sv
module exu_alu (
    input  rv_exec_pkg::uop_t            uop,
    output logic [rv_exec_pkg::XLEN-1:0] alu_result
);
    import rv_exec_pkg::*;

    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] i;

    assign a = uop.src1;
    assign b = uop.src2;
    assign i = uop.imm;

    always_comb begin
        alu_result = '0;
        case (uop.op)
            OP_ADD:  alu_result = a + b;
            OP_SUB:  alu_result = a - b;
            OP_SLTU: alu_result = {{(XLEN-1){1'b0}}, a < b};
            OP_ADDI: alu_result = a + i;
            OP_XORI: alu_result = a ^ i;
            OP_ANDI: alu_result = a & i;
            // Branch condition in bit 0.
            OP_BEQ:  alu_result = {{(XLEN-1){1'b0}}, a == b};
            OP_BNE:  alu_result = {{(XLEN-1){1'b0}}, a != b};
            OP_BGE:  alu_result = {{(XLEN-1){1'b0}}, $signed(a) >= $signed(b)};
            default: alu_result = '0;
        endcase
    end

endmodule

//--- credit_fifo.sv
module credit_fifo #(
    parameter int DEPTH = rv_exec_pkg::FIFO_DEPTH
) (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              push,
    input  rv_exec_pkg::uop_t push_uop,
    input  logic              pop,
    output logic              uop_valid,
    output rv_exec_pkg::uop_t uop,
    output logic              credit_return
);
    import rv_exec_pkg::*;

    typedef logic [$clog2(DEPTH)-1:0]   ptr_t;
    typedef logic [$clog2(DEPTH+1)-1:0] cnt_t;

    uop_t mem [DEPTH];
    ptr_t wr_ptr;
    ptr_t rd_ptr;
    cnt_t count;

    assign uop_valid = (count != '0);
    assign uop       = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_uop;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            credit_return <= 1'b0;
        end else begin
            credit_return <= pop;
            if (push) begin
                wr_ptr <= (wr_ptr == ptr_t'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ptr_t'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // The decoder only pushes while it holds a credit.
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- inst_decoder.sv
module inst_decoder (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  inst_valid,
    input  rv_exec_pkg::inst_in_t inst,
    input  logic                  credit_return,
    output logic                  inst_ready,
    output logic                  push,
    output rv_exec_pkg::uop_t     push_uop
);
    import rv_exec_pkg::*;

    logic [CREDIT_W-1:0] credits;
    logic                accept;
    logic [XLEN-1:0]     w;
    logic [6:0]          opcode;
    logic [2:0]          funct3;
    logic [6:0]          funct7;
    op_e                 op;
    logic [XLEN-1:0]     imm;

    assign w      = inst.word;
    assign opcode = w[6:0];
    assign funct3 = w[14:12];
    assign funct7 = w[31:25];

    assign inst_ready = (credits != '0);
    assign accept     = inst_valid && inst_ready;

    always_comb begin
        op  = OP_ILLEGAL;
        imm = '0;
        case (opcode)
            OPC_OP: begin
                if (funct7 == FUNCT7_BASE && funct3 == 3'b000) op = OP_ADD;
                if (funct7 == FUNCT7_ALT && funct3 == 3'b000) op = OP_SUB;
                if (funct7 == FUNCT7_BASE && funct3 == 3'b011) op = OP_SLTU;
            end
            OPC_OP_IMM: begin
                imm = {{20{w[31]}}, w[31:20]};
                if (funct3 == 3'b000) op = OP_ADDI;
                if (funct3 == 3'b100) op = OP_XORI;
                if (funct3 == 3'b111) op = OP_ANDI;
            end
            OPC_AUIPC: begin
                imm = {w[31:12], 12'b0};
                op  = OP_AUIPC;
            end
            OPC_JAL: begin
                imm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
                op  = OP_JAL;
            end
            OPC_JALR: begin
                imm = {{20{w[31]}}, w[31:20]};
                if (funct3 == 3'b000) op = OP_JALR;
            end
            OPC_BRANCH: begin
                imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
                if (funct3 == 3'b000) op = OP_BEQ;
                if (funct3 == 3'b001) op = OP_BNE;
                if (funct3 == 3'b101) op = OP_BGE;
            end
            OPC_SYSTEM: begin
                if (w == EBREAK_WORD) op = OP_EBREAK;
            end
            default: op = OP_ILLEGAL;
        endcase
    end

    // One credit per accepted instruction, one back per buffer pop.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            credits <= CREDIT_W'(FIFO_DEPTH);
            push    <= 1'b0;
        end else begin
            push <= accept;
            case ({accept, credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            push_uop <= '{op: op, rd: w[11:7], imm: imm, src1: inst.src1, src2: inst.src2};
        end
    end

endmodule

//--- rv_exec_pkg.sv
package rv_exec_pkg;

    localparam int XLEN       = 32;
    localparam int FIFO_DEPTH = 4;
    localparam int CREDIT_W   = $clog2(FIFO_DEPTH + 1);

    localparam logic [XLEN-1:0] RESET_PC = 32'h8000_0000;

    // Major opcodes of the supported RV32I subset.
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    localparam logic [6:0]      FUNCT7_BASE = 7'b0000000;
    localparam logic [6:0]      FUNCT7_ALT  = 7'b0100000;
    localparam logic [XLEN-1:0] EBREAK_WORD = 32'h0010_0073;

    typedef enum logic [3:0] {
        OP_ADD,
        OP_SUB,
        OP_SLTU,
        OP_ADDI,
        OP_XORI,
        OP_ANDI,
        OP_AUIPC,
        OP_JAL,
        OP_JALR,
        OP_BEQ,
        OP_BNE,
        OP_BGE,
        OP_EBREAK,
        OP_ILLEGAL
    } op_e;

    typedef struct packed {
        logic [XLEN-1:0] word;
        logic [XLEN-1:0] src1;
        logic [XLEN-1:0] src2;
    } inst_in_t;

    typedef struct packed {
        op_e             op;
        logic [4:0]      rd;
        logic [XLEN-1:0] imm;
        logic [XLEN-1:0] src1;
        logic [XLEN-1:0] src2;
    } uop_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] next_pc;
        logic [4:0]      rd;
        logic [XLEN-1:0] wdata;
        logic            wen;
        logic            halt;
        logic            illegal;
    } result_t;

endpackage
